// File: hw/uartPkg.sv
`default_nettype none

package uartPkg;

	localparam int clockScaleBits = 16;

	// local register map
	localparam logic [11:0] configOffset = 12'h000;
	localparam logic [11:0] clearOffset = 12'h004;
	localparam logic [11:0] statusOffset = 12'h008;
	localparam logic [11:0] rxOffset = 12'h010;
	localparam logic [11:0] txOffset = 12'h014;

	// cyclesPerBit holds the bit period minus one
	typedef struct packed {
		logic enable;
		logic waitForTxSpace;
		logic [clockScaleBits-1:0] cyclesPerBit;
	} uartConfig;

	typedef struct packed {
		logic txDataLost;
		logic txBufferFull;
		logic txByteOutAvailable;
		logic rxDataLost;
		logic rxBufferFull;
		logic rxDataAvailable;
	} uartStatus;

	typedef struct packed {
		logic txBuffer;
		logic rxBuffer;
		logic tx;
		logic rx;
	} uartClear;

	// 40 MHz clock at 9600 baud, disabled
	localparam uartConfig defaultConfig = uartConfig'(18'h01047);

endpackage

`default_nettype wire

// File: hw/byteFifo.sv
`timescale 1ns/1ps
`default_nettype none

module byteFifo #(
	parameter int bufferDepth = 16
) (
	input wire clk,
	input wire reset,
	input wire clear,
	input wire [7:0] dataIn,
	input wire push,
	input wire pop,
	output logic [7:0] dataOut,
	output logic isData,
	output logic bufferFull,
	output logic dataLost
);
	localparam int pointerBits = $clog2(bufferDepth);

	logic [7:0] storage [bufferDepth];
	logic [pointerBits-1:0] readPointer;
	logic [pointerBits-1:0] writePointer;
	logic [pointerBits:0] count;
	logic doPush;
	logic doPop;

	assign isData = (count != '0);
	assign bufferFull = (count == (pointerBits + 1)'(bufferDepth));
	assign doPop = pop && isData;
	// a simultaneous pop makes room
	assign doPush = push && (!bufferFull || doPop);
	assign dataOut = storage[readPointer];

	always_ff @(posedge clk) begin
		if (doPush) begin
			storage[writePointer] <= dataIn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			readPointer <= '0;
			writePointer <= '0;
			count <= '0;
			dataLost <= 1'b0;
		end else begin
			if (doPush) begin
				writePointer <= writePointer + 1'b1;
			end
			if (doPop) begin
				readPointer <= readPointer + 1'b1;
			end
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
			if (push && !doPush) begin
				dataLost <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/uartReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module uartReceiver (
	input wire clk,
	input wire reset,
	input wire clear,
	input wire [uartPkg::clockScaleBits-1:0] cyclesPerBit,
	input wire rx,
	output logic [7:0] dataOut,
	output logic byteValid
);
	import uartPkg::*;

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateType;

	rxStateType state;
	logic [1:0] rxSync;
	logic rxLast;
	logic [clockScaleBits-1:0] timer;
	logic [2:0] bitIndex;
	logic sampleNow;

	assign sampleNow = (timer == '0);

	// two-flop synchronizer plus edge history
	always_ff @(posedge clk) begin
		if (reset) begin
			rxSync <= 2'b11;
			rxLast <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rx};
			rxLast <= rxSync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			state <= rxIdle;
			timer <= '0;
			bitIndex <= '0;
			byteValid <= 1'b0;
		end else begin
			byteValid <= 1'b0;
			case (state)
				rxIdle: begin
					// half a period lands on the start bit midpoint
					if (rxLast && !rxSync[1]) begin
						timer <= cyclesPerBit >> 1;
						state <= rxStart;
					end
				end
				rxStart: begin
					if (!sampleNow) begin
						timer <= timer - 1'b1;
					end else if (!rxSync[1]) begin
						timer <= cyclesPerBit;
						bitIndex <= '0;
						state <= rxData;
					end else begin
						state <= rxIdle;
					end
				end
				rxData: begin
					if (!sampleNow) begin
						timer <= timer - 1'b1;
					end else begin
						timer <= cyclesPerBit;
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == 3'd7) begin
							state <= rxStop;
						end
					end
				end
				default: begin
					if (!sampleNow) begin
						timer <= timer - 1'b1;
					end else begin
						// framing error drops the byte
						byteValid <= rxSync[1];
						state <= rxIdle;
					end
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if ((state == rxData) && sampleNow) begin
			dataOut <= {rxSync[1], dataOut[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: hw/uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter (
	input wire clk,
	input wire reset,
	input wire clear,
	input wire [uartPkg::clockScaleBits-1:0] cyclesPerBit,
	input wire [7:0] dataIn,
	input wire dataAvailable,
	output logic tx,
	output logic busy
);
	import uartPkg::*;

	typedef enum logic {txIdle, txSend} txStateType;

	txStateType state;
	logic [clockScaleBits-1:0] timer;
	logic [3:0] bitsLeft;
	logic [9:0] frame;
	logic loadFrame;
	logic bitDone;

	assign busy = (state == txSend);
	assign loadFrame = dataAvailable && !busy;
	assign bitDone = (timer == '0);
	// line idles high
	assign tx = busy ? frame[0] : 1'b1;

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			state <= txIdle;
			timer <= '0;
			bitsLeft <= '0;
		end else begin
			case (state)
				txIdle: begin
					if (loadFrame) begin
						timer <= cyclesPerBit;
						bitsLeft <= 4'd9;
						state <= txSend;
					end
				end
				default: begin
					if (!bitDone) begin
						timer <= timer - 1'b1;
					end else if (bitsLeft == '0) begin
						state <= txIdle;
					end else begin
						timer <= cyclesPerBit;
						bitsLeft <= bitsLeft - 1'b1;
					end
				end
			endcase
		end
	end

	// stop, data, start from msb down
	always_ff @(posedge clk) begin
		if (loadFrame) begin
			frame <= {1'b1, dataIn, 1'b0};
		end else if (busy && bitDone) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

endmodule

`default_nettype wire

// File: hw/uartRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module uartRegisters #(
	parameter logic [3:0] deviceId = 4'h0
) (
	input wire clk,
	input wire reset,
	input wire peripheralEnable,
	input wire peripheralBusWe,
	input wire peripheralBusOe,
	input wire [15:0] peripheralBusAddress,
	input wire [3:0] peripheralBusByteSelect,
	input wire [31:0] peripheralBusDataWrite,
	output logic [31:0] peripheralBusDataRead,
	output logic requestOutput,
	output logic peripheralBusBusy,
	output uartPkg::uartConfig configuration,
	output uartPkg::uartClear clear,
	output logic txPush,
	output logic [7:0] txByte,
	output logic rxPop,
	input wire [7:0] rxByte,
	input wire uartPkg::uartStatus status
);
	import uartPkg::*;

	logic deviceSelect;
	logic [11:0] localAddress;
	logic writeStrobe;
	logic readStrobe;
	logic readMapped;
	logic [31:0] readValue;

	assign localAddress = peripheralBusAddress[11:0];
	assign deviceSelect = peripheralEnable && (peripheralBusAddress[15:12] == deviceId);

	// hold a tx write until the buffer has room
	assign peripheralBusBusy = peripheralBusWe && deviceSelect && (localAddress == txOffset)
		&& configuration.waitForTxSpace && status.txBufferFull && configuration.enable;

	assign writeStrobe = peripheralBusWe && deviceSelect && peripheralBusByteSelect[0]
		&& !peripheralBusBusy;
	assign readStrobe = peripheralBusOe && deviceSelect;

	always_ff @(posedge clk) begin
		if (reset) begin
			configuration <= defaultConfig;
		end else if (writeStrobe && (localAddress == configOffset)) begin
			configuration <= uartConfig'(peripheralBusDataWrite[$bits(uartConfig)-1:0]);
		end
	end

	// one-cycle strobes, one per written bit
	always_comb begin
		clear = '0;
		if (writeStrobe && (localAddress == clearOffset)) begin
			clear = uartClear'(peripheralBusDataWrite[$bits(uartClear)-1:0]);
		end
	end

	assign txPush = writeStrobe && (localAddress == txOffset);
	assign txByte = peripheralBusDataWrite[7:0];

	// an empty buffer is never popped
	assign rxPop = readStrobe && (localAddress == rxOffset) && status.rxDataAvailable;

	always_comb begin
		readMapped = 1'b1;
		readValue = '0;
		case (localAddress)
			configOffset: readValue = 32'(configuration);
			statusOffset: readValue = 32'(status);
			rxOffset: readValue = status.rxDataAvailable ? 32'(rxByte) : '0;
			txOffset: readValue = '0;
			default: readMapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			requestOutput <= 1'b0;
		end else begin
			requestOutput <= readStrobe && readMapped;
		end
	end

	// head byte is captured at the same edge that pops it
	always_ff @(posedge clk) begin
		peripheralBusDataRead <= (readStrobe && readMapped) ? readValue : '0;
	end

endmodule

`default_nettype wire

// File: hw/uartDevice.sv
`timescale 1ns/1ps
`default_nettype none

module uartDevice #(
	parameter logic [3:0] deviceId = 4'h0,
	parameter int bufferDepth = 16
) (
	input wire clk,
	input wire reset,

	// peripheral bus
	input wire peripheralEnable,
	input wire peripheralBusWe,
	input wire peripheralBusOe,
	output logic peripheralBusBusy,
	input wire [15:0] peripheralBusAddress,
	input wire [3:0] peripheralBusByteSelect,
	output logic [31:0] peripheralBusDataRead,
	input wire [31:0] peripheralBusDataWrite,
	output logic requestOutput,

	// serial side
	output logic uartEn,
	input wire uartRx,
	output logic uartTx
);
	import uartPkg::*;

	uartConfig configuration;
	uartClear clear;
	wire uartStatus status;
	logic txPush;
	logic [7:0] txByte;
	logic rxPop;
	logic [7:0] rxByte;
	logic [7:0] rxByteIn;
	logic rxByteValid;
	logic [7:0] txByteOut;
	logic txSendBusy;
	logic txReady;

	assign uartEn = configuration.enable;
	assign txReady = status.txByteOutAvailable && configuration.enable;

	uartRegisters #(.deviceId(deviceId)) registers (
		.clk(clk),
		.reset(reset),
		.peripheralEnable(peripheralEnable),
		.peripheralBusWe(peripheralBusWe),
		.peripheralBusOe(peripheralBusOe),
		.peripheralBusAddress(peripheralBusAddress),
		.peripheralBusByteSelect(peripheralBusByteSelect),
		.peripheralBusDataWrite(peripheralBusDataWrite),
		.peripheralBusDataRead(peripheralBusDataRead),
		.requestOutput(requestOutput),
		.peripheralBusBusy(peripheralBusBusy),
		.configuration(configuration),
		.clear(clear),
		.txPush(txPush),
		.txByte(txByte),
		.rxPop(rxPop),
		.rxByte(rxByte),
		.status(status));

	uartReceiver receiver (
		.clk(clk),
		.reset(reset),
		.clear(clear.rx),
		.cyclesPerBit(configuration.cyclesPerBit),
		.rx(uartRx),
		.dataOut(rxByteIn),
		.byteValid(rxByteValid));

	// received bytes are discarded while disabled
	byteFifo #(.bufferDepth(bufferDepth)) rxBuffer (
		.clk(clk),
		.reset(reset),
		.clear(clear.rxBuffer),
		.dataIn(rxByteIn),
		.push(rxByteValid && configuration.enable),
		.pop(rxPop),
		.dataOut(rxByte),
		.isData(status.rxDataAvailable),
		.bufferFull(status.rxBufferFull),
		.dataLost(status.rxDataLost));

	// pop in the cycle the transmitter latches the byte
	byteFifo #(.bufferDepth(bufferDepth)) txBuffer (
		.clk(clk),
		.reset(reset),
		.clear(clear.txBuffer),
		.dataIn(txByte),
		.push(txPush),
		.pop(txReady && !txSendBusy),
		.dataOut(txByteOut),
		.isData(status.txByteOutAvailable),
		.bufferFull(status.txBufferFull),
		.dataLost(status.txDataLost));

	uartTransmitter transmitter (
		.clk(clk),
		.reset(reset),
		.clear(clear.tx),
		.cyclesPerBit(configuration.cyclesPerBit),
		.dataIn(txByteOut),
		.dataAvailable(txReady),
		.tx(uartTx),
		.busy(txSendBusy));

endmodule

`default_nettype wire

// File: testbench/uartDevice_props.sv
`timescale 1ns/1ps
`default_nettype none

module uartDevice_props #(
	parameter logic [3:0] deviceId = 4'h0
) (
	input wire clk,
	input wire reset,
	input wire peripheralEnable,
	input wire peripheralBusOe,
	input wire [15:0] peripheralBusAddress,
	input wire peripheralBusBusy,
	input wire requestOutput,
	input wire uartTx,
	input wire uartPkg::uartConfig configuration,
	input wire uartPkg::uartStatus status
);
	import uartPkg::*;

	logic mappedRead;
	int failCount;

	initial failCount = 0;

	assign mappedRead = peripheralEnable && peripheralBusOe
		&& (peripheralBusAddress[15:12] == deviceId)
		&& (peripheralBusAddress[11:0] inside {configOffset, statusOffset, rxOffset, txOffset});

	// idle line and quiet bus right after reset
	resetState: assert property (@(posedge clk)
		reset |=> (uartTx && !requestOutput && !peripheralBusBusy))
		else begin
			$error("bus or serial line not idle after reset");
			failCount++;
		end

	readAck: assert property (@(posedge clk) disable iff (reset) mappedRead |=> requestOutput)
		else begin
			$error("requestOutput missing after a mapped read");
			failCount++;
		end

	ackOnlyAfterRead: assert property (@(posedge clk) disable iff (reset)
		requestOutput |-> $past(mappedRead))
		else begin
			$error("requestOutput without a mapped read one cycle before");
			failCount++;
		end

	busyCause: assert property (@(posedge clk)
		peripheralBusBusy |-> (configuration.waitForTxSpace && status.txBufferFull))
		else begin
			$error("busy without waitForTxSpace and a full tx buffer");
			failCount++;
		end

endmodule

`default_nettype wire

// File: testbench/uartDeviceTb.sv
`timescale 1ns/1ps
`default_nettype none

module uartDeviceTb;
	import uartPkg::*;

	localparam logic [3:0] deviceId = 4'h3;
	localparam int bufferDepth = 4;
	// 20 frames of 10 bits at 8 clocks per bit plus margin
	localparam int timeoutCycles = 20 * 10 * 8 + 2000;

	logic clk;
	logic reset;
	logic peripheralEnable;
	logic peripheralBusWe;
	logic peripheralBusOe;
	logic peripheralBusBusy;
	logic [15:0] peripheralBusAddress;
	logic [3:0] peripheralBusByteSelect;
	logic [31:0] peripheralBusDataRead;
	logic [31:0] peripheralBusDataWrite;
	logic requestOutput;
	logic uartEn;
	wire serialLine;
	logic [7:0] lfsrState;
	logic [7:0] sentBytes [$];
	logic [31:0] readData;
	logic readAck;
	int stalls;
	int totalStalls;

	// tx looped straight back into rx
	uartDevice #(.deviceId(deviceId), .bufferDepth(bufferDepth)) dut0 (
		.clk(clk),
		.reset(reset),
		.peripheralEnable(peripheralEnable),
		.peripheralBusWe(peripheralBusWe),
		.peripheralBusOe(peripheralBusOe),
		.peripheralBusBusy(peripheralBusBusy),
		.peripheralBusAddress(peripheralBusAddress),
		.peripheralBusByteSelect(peripheralBusByteSelect),
		.peripheralBusDataRead(peripheralBusDataRead),
		.peripheralBusDataWrite(peripheralBusDataWrite),
		.requestOutput(requestOutput),
		.uartEn(uartEn),
		.uartRx(serialLine),
		.uartTx(serialLine));

	bind uartDevice uartDevice_props #(.deviceId(deviceId)) props0 (
		.clk(clk),
		.reset(reset),
		.peripheralEnable(peripheralEnable),
		.peripheralBusOe(peripheralBusOe),
		.peripheralBusAddress(peripheralBusAddress),
		.peripheralBusBusy(peripheralBusBusy),
		.requestOutput(requestOutput),
		.uartTx(uartTx),
		.configuration(configuration),
		.status(status));

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else reportFailure($sformatf(
			"FAIL at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, expected, actual));
	endtask

	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	// one lfsr step per bit
	function automatic logic [7:0] nextTestByte();
		logic [7:0] value;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
		return value;
	endfunction

	// called 1 ns after a rising edge and returns at the same point
	task automatic writeRegister(input logic [11:0] offset, input logic [31:0] value,
		output int stallCycles);
		stallCycles = 0;
		peripheralEnable = 1'b1;
		peripheralBusWe = 1'b1;
		peripheralBusAddress = {deviceId, offset};
		peripheralBusByteSelect = 4'hf;
		peripheralBusDataWrite = value;
		@(negedge clk);
		while (peripheralBusBusy) begin
			stallCycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		peripheralEnable = 1'b0;
		peripheralBusWe = 1'b0;
		peripheralBusByteSelect = 4'h0;
	endtask

	task automatic readRegister(input logic [3:0] id, input logic [11:0] offset,
		output logic [31:0] data, output logic ack);
		peripheralEnable = 1'b1;
		peripheralBusOe = 1'b1;
		peripheralBusAddress = {id, offset};
		@(posedge clk);
		#1;
		peripheralEnable = 1'b0;
		peripheralBusOe = 1'b0;
		@(negedge clk);
		data = peripheralBusDataRead;
		ack = requestOutput;
		@(posedge clk);
		#1;
	endtask

	task automatic sendByte(output int stallCycles);
		logic [7:0] value;
		value = nextTestByte();
		sentBytes.push_back(value);
		writeRegister(txOffset, {24'h0, value}, stallCycles);
	endtask

	// poll status until a byte waits and then pop it
	task automatic expectRxByte(input logic [7:0] expected);
		logic [31:0] statusWord;
		logic ack;
		statusWord = '0;
		while (!statusWord[0]) begin
			readRegister(deviceId, statusOffset, statusWord, ack);
		end
		readRegister(deviceId, rxOffset, statusWord, ack);
		checkValue("requestOutput", 32'h1, {31'h0, ack});
		checkValue("rx data", {24'h0, expected}, statusWord);
	endtask

	task automatic expectRegister(input string name, input logic [11:0] offset,
		input logic [31:0] expected);
		logic [31:0] data;
		logic ack;
		readRegister(deviceId, offset, data, ack);
		checkValue("requestOutput", 32'h1, {31'h0, ack});
		checkValue(name, expected, data);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		reportFailure($sformatf("timeout after %0d cycles, the tests did not finish",
			timeoutCycles));
	end

	// a failed bound property ends the run at once
	always @(dut0.props0.failCount) begin
		if (dut0.props0.failCount != 0) begin
			reportFailure("a bound property assertion failed during the run");
		end
	end

	initial begin
		reset = 1'b1;
		peripheralEnable = 1'b0;
		peripheralBusWe = 1'b0;
		peripheralBusOe = 1'b0;
		peripheralBusAddress = '0;
		peripheralBusByteSelect = '0;
		peripheralBusDataWrite = '0;
		lfsrState = 8'd9;
		totalStalls = 0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		checkValue("uartEn", 32'h0, {31'h0, uartEn});
		expectRegister("config", configOffset, 32'h0001047);
		expectRegister("status", statusOffset, 32'h0);
		readRegister(4'h5, configOffset, readData, readAck);
		checkValue("peripheralBusDataRead", 32'h0, readData);
		checkValue("requestOutput", 32'h0, {31'h0, readAck});

		// enable at 8 clocks per bit
		writeRegister(configOffset, 32'h0002_0007, stalls);
		checkValue("uartEn", 32'h1, {31'h0, uartEn});
		expectRegister("config", configOffset, 32'h0002_0007);

		repeat (4) sendByte(stalls);
		while (sentBytes.size() > 0) expectRxByte(sentBytes.pop_front());
		expectRegister("status", statusOffset, 32'h0);

		// disabled so nothing drains and two writes are lost
		writeRegister(configOffset, 32'h0000_0007, stalls);
		checkValue("uartEn", 32'h0, {31'h0, uartEn});
		repeat (6) sendByte(stalls);
		expectRegister("status", statusOffset, 32'h38);
		writeRegister(clearOffset, 32'h8, stalls);
		expectRegister("status", statusOffset, 32'h0);
		sentBytes.delete();

		// wait for tx space so the last write stalls on a full buffer
		writeRegister(configOffset, 32'h0003_0007, stalls);
		repeat (6) begin
			sendByte(stalls);
			totalStalls += stalls;
		end
		assert (totalStalls > 0) else reportFailure("busy never held a write to the full tx buffer");
		while (sentBytes.size() > 0) expectRxByte(sentBytes.pop_front());
		expectRegister("status", statusOffset, 32'h0);

		if (dut0.props0.failCount == 0) begin
			$display("test passed");
			$finish;
		end else begin
			reportFailure("a bound property assertion failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: build.f
hw/uartPkg.sv
hw/byteFifo.sv
hw/uartReceiver.sv
hw/uartTransmitter.sv
hw/uartRegisters.sv
hw/uartDevice.sv
testbench/uartDevice_props.sv
testbench/uartDeviceTb.sv
